// ==== rtl/sleepCtrl_settings.svh ====
`ifndef SLEEPCTRL_SETTINGS_SVH
`define SLEEPCTRL_SETTINGS_SVH

// ##########################################################################
// Halt sources
// ##########################################################################
`define HALT_SRC_COUNT    8
`define HALT_IGNORE_MASK  8'h01   // ALU halt never blocks sleep.
`define HALT_OWN_MASK     8'h06   // Sleep halt and data cache drain.

// ##########################################################################
// Fanout and interrupt widths
// ##########################################################################
`define HALT_DRV_COUNT    4
`define CLUSTER_COUNT     4
`define INT_COUNT         6

// Settling time in stChill, 1 to 15.
`define SLEEP_CHILL_CYCLES 5
`define SLEEP_CNT_WIDTH    4

`endif

// ==== rtl/sleepPkg.sv ====
`default_nettype none

package sleepPkg;

  // ##########################################################################
  // Sleep sequence states
  // ##########################################################################
  typedef enum logic [3:0]
  {
    stIdle   = 4'd0,  // Core running.
    stHalt   = 4'd1,
    stCool   = 4'd2,  // Other halts still active.
    stChill  = 4'd3,  // Fixed settling time.
    stCold   = 4'd4,  // Write buffer drain.
    stFrozen = 4'd5,
    stThaw   = 4'd6
  } sleepStateT;

  // ##########################################################################
  // Stage to stage bundles
  // ##########################################################################

  // Conditioned wake and request terms.
  typedef struct packed
  {
    logic intPend;    // Unmasked or debug interrupt, two cycles late.
    logic extReq;     // External sleep request, one cycle late.
    logic anyHalt;
    logic otherHalt;  // Without the sleep path's own halts.
  } wakeCondT;

  // Decoded from the next state.
  typedef struct packed
  {
    logic haltNext;
    logic frozenNext;
  } sleepCtlT;

endpackage

`default_nettype wire

// ==== rtl/resetSync.sv ====
`timescale 1ns/1ps
`default_nettype none

module resetSync
(
  input  wire logic SYSCLKF,
  input  wire logic rstN,       // Board reset.
  input  wire logic pwrOnRstN,
  input  wire logic jtagRstN,
  input  wire logic dbgRst,     // Debug reset, active high.
  input  wire logic testModeN,
  output logic      coreRstN,
  output logic      ctlRstN
);

  logic allRstN;
  logic syncQ0;
  logic syncQ1;
  logic ctlQ;

  // Any source low resets the core.
  assign allRstN = rstN & pwrOnRstN & jtagRstN & ~dbgRst;

  // ##########################################################################
  // Synchronizer
  // ##########################################################################
  always_ff @(posedge SYSCLKF)
  begin
    syncQ0 <= allRstN;
    syncQ1 <= syncQ0;
  end

  assign coreRstN = syncQ1;

  // Controller reset lags the core reset by one cycle.
  always_ff @(posedge SYSCLKF)
  begin
    ctlQ <= syncQ1;
  end

  assign ctlRstN = ctlQ | ~testModeN;  // Held high during scan.

  // ##########################################################################
  // Assertions
  // ##########################################################################
  property pCoreRstFollows;
    @(posedge SYSCLKF) !rstN |-> ##2 !coreRstN;
  endproperty

  aCoreRstFollows : assert property (pCoreRstFollows)
    else $error("coreRstN not low 2 cycles after rstN.");

endmodule

`default_nettype wire

// ==== rtl/wakeDetect.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sleepCtrl_settings.svh"

module wakeDetect
  import sleepPkg::*;
(
  input  wire logic                         SYSCLKF,
  input  wire logic                         rstN,
  input  wire logic [`INT_COUNT-1:0]        intMask,
  input  wire logic [`INT_COUNT-1:0]        intReqN,   // Active low.
  input  wire logic                         dbgInt,
  input  wire logic                         extSleepReq,
  input  wire logic [`HALT_SRC_COUNT-1:0]   haltSrc,
  output wakeCondT                          wake
);

  logic intPendRaw;
  logic intPendQ0;
  logic intPendQ1;
  logic extReqQ;
  logic anyHalt;
  logic otherHalt;

  // ##########################################################################
  // Halt reduction
  // ##########################################################################
  assign anyHalt   = |(haltSrc & ~`HALT_IGNORE_MASK);
  assign otherHalt = |(haltSrc & ~(`HALT_IGNORE_MASK | `HALT_OWN_MASK));

  // ##########################################################################
  // Interrupt and request registers
  // ##########################################################################
  assign intPendRaw = (|(intMask & ~intReqN)) | dbgInt;

  always_ff @(posedge SYSCLKF)
  begin
    if (!rstN)
    begin
      intPendQ0 <= 1'b0;
      intPendQ1 <= 1'b0;
      extReqQ   <= 1'b0;
    end
    else
    begin
      intPendQ0 <= intPendRaw;
      intPendQ1 <= intPendQ0;  // Second stage.
      extReqQ   <= extSleepReq;
    end
  end

  assign wake = '{
    intPend:   intPendQ1,
    extReq:    extReqQ,
    anyHalt:   anyHalt,
    otherHalt: otherHalt
  };

endmodule

`default_nettype wire

// ==== rtl/sleepFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sleepCtrl_settings.svh"

module sleepFsm
  import sleepPkg::*;
(
  input  wire logic     SYSCLKF,
  input  wire logic     rstN,
  input  wire logic     sleepEnable,
  input  wire logic     sleepInstr,
  input  wire logic     wbEmpty,      // Write buffer empty.
  input  wire wakeCondT wake,
  output sleepCtlT      ctl
);

  localparam int ChillMax = (1 << `SLEEP_CNT_WIDTH) - 1;

  sleepStateT                  state;
  sleepStateT                  stateNext;
  logic [`SLEEP_CNT_WIDTH-1:0] chillCnt;
  logic                        snooze;
  logic                        wakeUp;
  logic                        sleepReq;

  if (`SLEEP_CHILL_CYCLES < 1 || `SLEEP_CHILL_CYCLES > ChillMax)
  begin : gBadChill
    $error("SLEEP_CHILL_CYCLES out of range.");
  end

  assign sleepReq = (sleepInstr | wake.extReq) & ~wake.anyHalt & sleepEnable;

  // Snooze wakes on the request dropping, otherwise on an interrupt.
  assign wakeUp = snooze ? ~wake.extReq : wake.intPend;

  // ##########################################################################
  // Next state
  // ##########################################################################
  always_comb
  begin
    stateNext = state;
    case (state)
      stIdle:
        if (sleepReq)
          stateNext = stHalt;
      stHalt:
        stateNext = stCool;
      stCool:
        if (!wake.otherHalt)
          stateNext = stChill;
      stChill:
        if (chillCnt == `SLEEP_CNT_WIDTH'(1))
          stateNext = stCold;
      stCold:
        if (wbEmpty)
          stateNext = stFrozen;
      stFrozen:
        if (wakeUp)
          stateNext = stThaw;
      stThaw:
        stateNext = stIdle;
      default:
        stateNext = stIdle;
    endcase
  end

  // ##########################################################################
  // State, chill counter and snooze
  // ##########################################################################
  always_ff @(posedge SYSCLKF)
  begin
    if (!rstN)
    begin
      state    <= stIdle;
      chillCnt <= '0;
      snooze   <= 1'b0;
    end
    else
    begin
      state <= stateNext;
      if (state == stCool)
        chillCnt <= `SLEEP_CNT_WIDTH'(`SLEEP_CHILL_CYCLES);  // Reload.
      else if (state == stChill)
        chillCnt <= chillCnt - 1'b1;
      if (state == stIdle)
        snooze <= wake.extReq;
    end
  end

  assign ctl = '{
    haltNext:   (stateNext != stIdle),
    frozenNext: (stateNext == stFrozen)
  };

  // ##########################################################################
  // Assertions
  // ##########################################################################
  property pNoSpuriousThaw;
    @(posedge SYSCLKF) disable iff (!rstN)
      (state == stFrozen) ##1 (state != stFrozen) |-> $past(wakeUp);
  endproperty

  property pHaltOneCycle;
    @(posedge SYSCLKF) disable iff (!rstN)
      (state == stHalt) |=> (state == stCool);
  endproperty

  aNoSpuriousThaw : assert property (pNoSpuriousThaw)
    else $error("Left stFrozen without a wake condition.");

  aHaltOneCycle : assert property (pHaltOneCycle)
    else $error("stHalt lasted more than one cycle.");

endmodule

`default_nettype wire

// ==== rtl/sleepFanout.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sleepCtrl_settings.svh"

module sleepFanout
  import sleepPkg::*;
(
  input  wire logic                        SYSCLKF,
  input  wire logic                        rstN,
  input  wire sleepCtlT                    ctl,
  input  wire logic                        scanEnN,
  input  wire logic                        testModeN,
  output logic [`HALT_DRV_COUNT-1:0]       haltDrv,
  output logic [`CLUSTER_COUNT-1:0]        sleepSys,
  output logic [`CLUSTER_COUNT-1:0]        sleepBus,
  output logic                             sleepSysGate
);

  logic busDly;

  // ##########################################################################
  // Halt and system sleep copies
  // ##########################################################################
  always_ff @(posedge SYSCLKF)
  begin
    if (!rstN)
    begin
      haltDrv  <= '0;
      sleepSys <= '0;
    end
    else
    begin
      haltDrv  <= {`HALT_DRV_COUNT{ctl.haltNext}};
      sleepSys <= {`CLUSTER_COUNT{ctl.frozenNext}};
    end
  end

  // ##########################################################################
  // Bus side, two stages behind sleepSys
  // ##########################################################################
  always_ff @(posedge SYSCLKF)
  begin
    if (!rstN)
    begin
      busDly   <= 1'b0;
      sleepBus <= '0;
    end
    else
    begin
      busDly   <= sleepSys[0];
      sleepBus <= {`CLUSTER_COUNT{busDly}};
    end
  end

  // Scan shift or test mode forces the enable off.
  assign sleepSysGate = sleepSys[0] & scanEnN & testModeN;

endmodule

`default_nettype wire

// ==== rtl/powerCtrlTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sleepCtrl_settings.svh"

module powerCtrlTop
  import sleepPkg::*;
(
  input  wire logic                        SYSCLKF,
  input  wire logic                        rstN,
  input  wire logic                        pwrOnRstN,
  input  wire logic                        jtagRstN,
  input  wire logic                        dbgRst,
  input  wire logic                        testModeN,
  input  wire logic                        scanEnN,
  input  wire logic                        sleepEnable,
  input  wire logic                        sleepInstr,
  input  wire logic                        extSleepReq,
  input  wire logic [`INT_COUNT-1:0]       intMask,
  input  wire logic [`INT_COUNT-1:0]       intReqN,
  input  wire logic                        dbgInt,
  input  wire logic [`HALT_SRC_COUNT-1:0]  haltSrc,
  input  wire logic                        wbEmpty,
  output logic                             coreRstN,
  output logic [`HALT_DRV_COUNT-1:0]       haltDrv,
  output logic [`CLUSTER_COUNT-1:0]        sleepSys,
  output logic [`CLUSTER_COUNT-1:0]        sleepBus,
  output logic                             sleepSysGate
);

  logic     ctlRstN;
  wakeCondT wake;
  sleepCtlT ctl;

  resetSync resetSync0 (
    .SYSCLKF   (SYSCLKF),
    .rstN      (rstN),
    .pwrOnRstN (pwrOnRstN),
    .jtagRstN  (jtagRstN),
    .dbgRst    (dbgRst),
    .testModeN (testModeN),
    .coreRstN  (coreRstN),
    .ctlRstN   (ctlRstN)
  );

  wakeDetect wakeDetect0 (
    .SYSCLKF     (SYSCLKF),
    .rstN        (ctlRstN),
    .intMask     (intMask),
    .intReqN     (intReqN),
    .dbgInt      (dbgInt),
    .extSleepReq (extSleepReq),
    .haltSrc     (haltSrc),
    .wake        (wake)
  );

  sleepFsm sleepFsm0 (
    .SYSCLKF     (SYSCLKF),
    .rstN        (ctlRstN),
    .sleepEnable (sleepEnable),
    .sleepInstr  (sleepInstr),
    .wbEmpty     (wbEmpty),
    .wake        (wake),
    .ctl         (ctl)
  );

  sleepFanout sleepFanout0 (
    .SYSCLKF      (SYSCLKF),
    .rstN         (ctlRstN),
    .ctl          (ctl),
    .scanEnN      (scanEnN),
    .testModeN    (testModeN),
    .haltDrv      (haltDrv),
    .sleepSys     (sleepSys),
    .sleepBus     (sleepBus),
    .sleepSysGate (sleepSysGate)
  );

endmodule

`default_nettype wire

// ==== testbench/powerCtrlTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sleepCtrl_settings.svh"

module powerCtrlTb;

  localparam int ScnCount   = 13;
  localparam int EntryEdges = 3 + `SLEEP_CHILL_CYCLES;  // Halt, cool, chill, cold.

  logic SYSCLKF;
  logic rstN;
  logic pwrOnRstN;
  logic jtagRstN;
  logic dbgRst;
  logic testModeN;
  logic scanEnN;
  logic sleepEnable;
  logic sleepInstr;
  logic extSleepReq;
  logic dbgInt;
  logic wbEmpty;
  logic coreRstN;
  logic sleepSysGate;
  logic [`INT_COUNT-1:0]      intMask;
  logic [`INT_COUNT-1:0]      intReqN;
  logic [`HALT_SRC_COUNT-1:0] haltSrc;
  logic [`HALT_DRV_COUNT-1:0] haltDrv;
  logic [`CLUSTER_COUNT-1:0]  sleepSys;
  logic [`CLUSTER_COUNT-1:0]  sleepBus;

  logic [7:0]  scnMem [0:8*ScnCount-1];  // Eight fields per scenario.
  logic [31:0] lfsr;
  int          errors = 0;
  int          passedTests = 0;
  int          failedTests = 0;

  powerCtrlTop dut0 (.*);

  initial
  begin
    SYSCLKF = 1'b0;
    forever #5 SYSCLKF = ~SYSCLKF;
  end

  // ##########################################################################
  // Helpers
  // ##########################################################################
  task automatic stepCycles(input int n);
    repeat (n)
    begin
      @(posedge SYSCLKF);
      @(negedge SYSCLKF);  // Sample and drive here.
    end
  endtask

  task automatic reportError(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    errors++;
  endtask

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
      n = n ^ 32'h80200003;
    return n;
  endfunction

  task automatic takeBits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      v = (v << 1) | lfsr[0];
      lfsr = lfsrNext(lfsr);
    end
  endtask

  // 0 sleepSys, 1 haltDrv, 2 sleepBus, 3 coreRstN.
  function automatic logic outBit(input int sel);
    case (sel)
      0: return sleepSys[0];
      1: return haltDrv[0];
      2: return sleepBus[0];
      default: return coreRstN;
    endcase
  endfunction

  task automatic countUntil(input int sel, input logic level, inout int cyc);
    while (outBit(sel) !== level && cyc < 60)
    begin
      stepCycles(1);
      cyc++;
    end
    if (outBit(sel) !== level)
      cyc = -1;  // Never got there.
  endtask

  task automatic checkQuiet(input string where);
    if (coreRstN !== 1'b1 || haltDrv !== '0 || sleepSys !== '0 || sleepBus !== '0
        || sleepSysGate !== 1'b0)
      reportError({"outputs not idle ", where});
  endtask

  task automatic logTest(input string name, input int errBefore);
    if (errors == errBefore)
    begin
      passedTests++;
      $display("%s: ok", name);
    end
    else
    begin
      failedTests++;
      $display("%s: %0d errors", name, errors - errBefore);
    end
  endtask

  task automatic restoreIdle;
    sleepInstr  = 1'b0;
    extSleepReq = 1'b0;
    stepCycles(2);  // Let extReq drain before halts clear.
    haltSrc = '0;
    intMask = '0;
    intReqN = '1;
    wbEmpty = 1'b1;
    scanEnN = 1'b1;
    stepCycles(4);
  endtask

  // ##########################################################################
  // Scenarios
  // ##########################################################################
  task automatic checkWake(input int sysLat);
    int cyc;
    cyc = 0;
    countUntil(0, 1'b0, cyc);
    if (cyc != sysLat)
      reportError($sformatf("sleepSys fell after %0d cycles, expected %0d", cyc, sysLat));
    countUntil(1, 1'b0, cyc);
    if (cyc != sysLat + 1)
      reportError($sformatf("haltDrv fell after %0d cycles, expected %0d", cyc, sysLat + 1));
    countUntil(2, 1'b0, cyc);
    if (cyc != sysLat + 2)
      reportError($sformatf("sleepBus fell after %0d cycles, expected %0d", cyc, sysLat + 2));
  endtask

  task automatic runResetPulse(input logic useDbg);
    int cyc;
    if (useDbg)
      dbgRst = 1'b1;
    else
      jtagRstN = 1'b0;
    cyc = 0;
    countUntil(3, 1'b0, cyc);
    if (cyc != 2)
      reportError($sformatf("coreRstN fell after %0d cycles, expected 2", cyc));
    stepCycles(1);
    dbgRst   = 1'b0;
    jtagRstN = 1'b1;
    cyc = 0;
    countUntil(3, 1'b1, cyc);
    if (cyc != 2)
      reportError($sformatf("coreRstN rose after %0d cycles, expected 2", cyc));
    stepCycles(2);  // Controller reset is one cycle later.
    checkQuiet("after reset pulse");
  endtask

  task automatic runSleep(input int b);
    int reqDelay;
    int wbLow;
    int result;
    int cyc;
    int dly;
    reqDelay    = scnMem[b+2][0] ? 2 : 1;  // External request is registered once.
    wbLow       = scnMem[b+6];
    result      = scnMem[b+7];
    sleepEnable = scnMem[b+1][0];
    haltSrc     = scnMem[b+3][`HALT_SRC_COUNT-1:0];
    intMask     = scnMem[b+4][`INT_COUNT-1:0];
    wbEmpty     = (wbLow == 0);
    sleepInstr  = !scnMem[b+2][0];
    extSleepReq = scnMem[b+2][0];
    if (result == 0)
    begin
      repeat (20)
      begin
        stepCycles(1);
        sleepInstr = 1'b0;
        if (haltDrv !== '0 || sleepSys !== '0)
          reportError("sleep entry started while blocked");
      end
      return;
    end
    cyc = 0;
    while (sleepSys[0] !== 1'b1 && cyc < 60)
    begin
      stepCycles(1);
      cyc++;
      sleepInstr = 1'b0;
      if (cyc == reqDelay + EntryEdges - 1 + wbLow)
        wbEmpty = 1'b1;  // Write buffer drains in stCold.
      if (haltDrv !== {`HALT_DRV_COUNT{cyc >= reqDelay}})
        reportError("haltDrv wrong during sleep entry");
    end
    if (cyc != reqDelay + EntryEdges + wbLow)
      reportError($sformatf("sleepSys rose after %0d cycles, expected %0d",
                            cyc, reqDelay + EntryEdges + wbLow));
    stepCycles(1);
    if (sleepBus !== '0 || sleepSysGate !== 1'b1)
      reportError("sleepBus early or sleepSysGate low");
    stepCycles(1);
    if (sleepBus !== '1)
      reportError("sleepBus not high 2 cycles after sleepSys");
    if (scnMem[b] == 8'd2)
    begin
      scanEnN = 1'b0;
      stepCycles(1);
      if (sleepSysGate !== 1'b0 || sleepSys !== '1)
        reportError("scan shift did not gate sleepSysGate");
      scanEnN = 1'b1;
    end
    if (result != 1)
      intReqN = scnMem[b+5][`INT_COUNT-1:0];  // Masked or snoozed interrupt that must not wake.
    takeBits(3, dly);
    repeat (dly + 2)
    begin
      stepCycles(1);
      if (sleepSys !== '1)
        reportError("woke before the wake event");
    end
    if (result == 3)
    begin
      extSleepReq = 1'b0;
      checkWake(2);
    end
    else
    begin
      intReqN = scnMem[b+5][`INT_COUNT-1:0];
      if (result == 2)
        intMask = '1;
      checkWake(3);
    end
  endtask

  // ##########################################################################
  // Main sequence and watchdog
  // ##########################################################################
  initial
  begin
    int cyc;
    int base;
    int errBefore;
    rstN        = 1'b0;
    pwrOnRstN   = 1'b1;
    jtagRstN    = 1'b1;
    dbgRst      = 1'b0;
    testModeN   = 1'b1;
    scanEnN     = 1'b1;
    sleepEnable = 1'b0;
    sleepInstr  = 1'b0;
    extSleepReq = 1'b0;
    intMask     = '0;
    intReqN     = '1;
    dbgInt      = 1'b0;
    haltSrc     = '0;
    wbEmpty     = 1'b1;
    lfsr        = 32'hf288233a;
    $readmemh("testbench/powerCtrl_input.txt", scnMem);
    stepCycles(2);
    rstN = 1'b1;
    cyc = 0;
    countUntil(3, 1'b1, cyc);
    if (cyc != 2)
      reportError($sformatf("coreRstN rose after %0d cycles, expected 2", cyc));
    stepCycles(2);
    checkQuiet("after power-up reset");
    logTest("Power-up reset", 0);
    for (int s = 0; s < ScnCount; s++)
    begin
      errBefore = errors;
      base = 8 * s;
      if (scnMem[base] == 8'd0)
        runResetPulse(scnMem[base+2][0]);
      else
        runSleep(base);
      restoreIdle();
      logTest($sformatf("Scenario %0d kind %0d", s, scnMem[base]), errBefore);
    end
    $display("Tests: %0d passed, %0d failed, %0d errors", passedTests, failedTests, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

  initial
  begin
    repeat (ScnCount * 200 + 100) @(posedge SYSCLKF);
    $display("Timeout: the run did not finish within %0d cycles.", ScnCount * 200 + 100);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+rtl
rtl/sleepPkg.sv
rtl/resetSync.sv
rtl/wakeDetect.sv
rtl/sleepFsm.sv
rtl/sleepFanout.sv
rtl/powerCtrlTop.sv
testbench/powerCtrlTb.sv

// ==== testbench/powerCtrl_input.txt ====
// kind en src halt mask reqN wbLow result   (all hex)
// kind 0 reset pulse, 1 sleep, 2 sleep plus scan check; src 0 instr or jtag, 1 ext or dbg
// result 0 blocked, 1 irq wake, 2 masked irq then unmasked, 3 snooze wake on ext drop
00 00 00 00 00 3f 00 00   // JTAG reset pulse
00 00 01 00 00 3f 00 00   // Debug reset pulse
01 01 00 00 3f 3e 00 01   // Instruction sleep, irq0 wakes
01 01 00 00 3f 3b 03 01   // Write buffer busy 3 cycles
01 01 00 00 01 3d 00 02   // irq1 masked at first
01 00 00 00 3f 3e 00 00   // Sleep disabled
01 00 01 00 3f 3e 00 00   // Sleep disabled, external request
01 01 00 10 3f 3e 00 00   // Halt source 4 blocks
01 01 00 02 3f 3e 00 00   // Own sleep halt still blocks entry
01 01 00 01 3f 3e 00 01   // Ignored halt bit
01 01 01 00 3f 3e 00 03   // Snooze by external request
01 01 01 00 3f 1f 06 03   // Snooze, write buffer busy 6 cycles
02 01 00 00 3f 3e 02 01   // Scan shift while asleep
